// File: all.f
verilog/rxdp_cfg_pkg.sv
verilog/rxdp_fifo_pkg.sv
verilog/rxdp_word_align.sv
verilog/rxdp_fifo_ptr.sv
verilog/rxdp_rate_packer.sv
verilog/rxdp_fifo_ram.sv
verilog/rxdp_fifo_flags.sv
verilog/rxdp_async_fifo.sv
test/tb_clkgen.sv
test/tb_rxdp_async_fifo.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f all.f --top-module tb_rxdp_async_fifo \
   -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1

// File: test/tb_rxdp_async_fifo.sv
`timescale 1ns/1ns
`default_nettype none

// Directed testbench for the receive datapath FIFO
module tb_rxdp_async_fifo
   import rxdp_cfg_pkg::*;
   import rxdp_fifo_pkg::*;
();

   localparam int DW         = 80;
   localparam int AW         = 4;
   localparam int PERIOD     = 40;
   localparam int WAIT_LIMIT = 40;   // Cycles allowed for a flag to arrive

   // **************************************************
   // Test lengths in clock cycles, for the watchdog
   // **************************************************
   localparam int LEN_RESET  = 20;
   localparam int LEN_ORDER  = 40;
   localparam int LEN_PACK   = 80;
   localparam int LEN_FLAGS  = 160;
   localparam int LEN_ALIGN  = 100;
   localparam int RUN_CYCLES = LEN_RESET + LEN_ORDER + LEN_PACK + LEN_FLAGS + LEN_ALIGN;

   logic            wr_clk;
   logic            rd_clk;
   logic            wr_rst_n;
   logic            rd_rst_n;
   logic            rst_req;
   logic            wr_en;
   logic [DW-1:0]   wr_data;
   logic            rd_en;
   fifo_thresh_t    thresh;
   fifo_mode_e      fifo_mode;
   logic            wa_en;
   logic [4*DW-1:0] rd_data;
   logic            wa_lock;
   fifo_flags_t     wr_flags;
   fifo_flags_t     rd_flags;

   int            seed = 13;     // Fixed seed for data words
   int            n_checks = 0;
   int            n_errors = 0;
   int            err_mark = 0;  // Error count at start of test
   logic [DW-1:0] words [8];     // Words written in the current test

   tb_clkgen #(.PERIOD(PERIOD), .RD_OFFSET(13), .RST_CYCLES(10)) clkgen (
      .rst_req  (rst_req),
      .wr_clk   (wr_clk),
      .rd_clk   (rd_clk),
      .wr_rst_n (wr_rst_n),
      .rd_rst_n (rd_rst_n)
   );

   rxdp_async_fifo #(.DWIDTH(DW), .AWIDTH(AW)) dut0 (
      .wr_clk    (wr_clk),
      .wr_rst_n  (wr_rst_n),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .rd_clk    (rd_clk),
      .rd_rst_n  (rd_rst_n),
      .rd_en     (rd_en),
      .thresh    (thresh),
      .fifo_mode (fifo_mode),
      .wa_en     (wa_en),
      .rd_data   (rd_data),
      .wa_lock   (wa_lock),
      .wr_flags  (wr_flags),
      .rd_flags  (rd_flags)
   );

   // **************************************************
   // Helpers
   // **************************************************
   function automatic logic [DW-1:0] random_word();
      logic [95:0] r;
      r = {$random(seed), $random(seed), $random(seed)};
      return r[DW-1:0];
   endfunction

   // Flag rules: low side at or below, high side at or above
   function automatic fifo_flags_t expected_flags(input int lvl);
      fifo_flags_t f;
      f.empty  = (lvl <= int'(thresh.empty));
      f.pempty = (lvl <= int'(thresh.pempty));
      f.full   = (lvl >= int'(thresh.full));
      f.pfull  = (lvl >= int'(thresh.pfull));
      return f;
   endfunction

   task automatic check(input string name, input logic [4*DW-1:0] got,
                        input logic [4*DW-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      $display("%s: done, %0d errors", name, n_errors - err_mark);
      err_mark = n_errors;
   endtask

   task automatic wait_reset_done();
      while (!(wr_rst_n && rd_rst_n)) begin
         @(negedge wr_clk);
      end
      @(negedge wr_clk);
   endtask

   task automatic apply_reset();
      @(posedge wr_clk);
      rst_req <= 1'b1;
      repeat (2) @(posedge wr_clk);   // Seen by both domains
      rst_req <= 1'b0;
      wait_reset_done();
   endtask

   task automatic set_mode(input fifo_mode_e mode);
      @(posedge wr_clk);
      fifo_mode <= mode;
      @(posedge wr_clk);   // Lane counter restarts
   endtask

   task automatic write_word(input logic [DW-1:0] w);
      @(posedge wr_clk);
      wr_en   <= 1'b1;
      wr_data <= w;
      @(posedge wr_clk);
      wr_en   <= 1'b0;
   endtask

   task automatic read_pulse();
      @(posedge rd_clk);
      rd_en <= 1'b1;
      @(posedge rd_clk);
      rd_en <= 1'b0;
   endtask

   // Show-ahead, so sample before popping
   task automatic read_entry(output logic [4*DW-1:0] d);
      @(negedge rd_clk);
      d = rd_data;
      read_pulse();
   endtask

   task automatic wait_rd_data();
      int n;
      n = 0;
      while (rd_flags.empty && n < WAIT_LIMIT) begin
         @(negedge rd_clk);
         n++;
      end
      if (rd_flags.empty) begin
         n_errors++;
         $display("ERROR: rd_flags.empty never went low after the writes");
      end
   endtask

   // Both domains must reach the flags of the known level
   task automatic settle_flags(input int lvl);
      fifo_flags_t exp;
      int          n;
      exp = expected_flags(lvl);
      n = 0;
      while (wr_flags != exp && n < WAIT_LIMIT) begin
         @(negedge wr_clk);
         n++;
      end
      n = 0;
      while (rd_flags != exp && n < WAIT_LIMIT) begin
         @(negedge rd_clk);
         n++;
      end
      check("wr_flags", wr_flags, exp);
      check("rd_flags", rd_flags, exp);
   endtask

   // **************************************************
   // Tests
   // **************************************************
   task automatic test_reset_values();
      fifo_flags_t exp;
      exp = '{empty: 1'b1, pempty: 1'b1, full: 1'b0, pfull: 1'b0};
      check("wr_flags", wr_flags, exp);
      check("rd_flags", rd_flags, exp);
      check("wa_lock", wa_lock, 1'b0);
   endtask

   task automatic test_full_rate_order();
      logic [4*DW-1:0] got;
      int              i;
      set_mode(FIFO_1X);
      for (i = 0; i < 5; i++) begin
         words[i] = random_word();
         write_word(words[i]);
      end
      wait_rd_data();
      for (i = 0; i < 5; i++) begin
         read_entry(got);
         check("rd_data lane 0", got[DW-1:0], words[i]);
         check("rd_data upper lanes", got[4*DW-1:DW], '0);
      end
   endtask

   task automatic test_packing(input fifo_mode_e mode, input int group);
      logic [4*DW-1:0] got;
      logic [4*DW-1:0] exp;
      int              i;
      int              k;
      set_mode(mode);
      for (i = 0; i < 8; i++) begin
         words[i] = random_word();
         write_word(words[i]);
      end
      wait_rd_data();
      for (i = 0; i < 8 / group; i++) begin
         exp = '0;   // Unused lanes stay zero
         for (k = 0; k < group; k++) begin
            exp[k*DW +: DW] = words[i*group + k];   // Earliest word in lane 0
         end
         read_entry(got);
         check("rd_data", got, exp);
      end
   endtask

   // Each target crosses a threshold, so settled flags pin the level
   task automatic test_flags();
      int targets [8];
      int level;
      int t;
      targets = '{1, 3, 10, 14, 13, 9, 2, 0};
      level = 0;
      set_mode(FIFO_1X);
      for (t = 0; t < 8; t++) begin
         while (level < targets[t]) begin
            write_word(random_word());
            level++;
         end
         while (level > targets[t]) begin
            read_pulse();
            level--;
         end
         settle_flags(level);
      end
   endtask

   // Marker every 'period' words, starting at word period-1
   task automatic send_markers(input int period, input int lock_at);
      logic [DW-1:0] w;
      int            i;
      for (i = 0; i < 16; i++) begin
         @(posedge wr_clk);   // Samples word i-1
         w = random_word();
         w[DW-2] = (i % period == period - 1);
         wr_data <= w;
         wa_en   <= 1'b1;
         @(negedge wr_clk);
         if (i > 0) begin
            check("wa_lock", wa_lock, (i - 1 >= lock_at));
         end
      end
      @(posedge wr_clk);
      wa_en <= 1'b0;
      @(negedge wr_clk);
      check("wa_lock", wa_lock, (15 >= lock_at));
   endtask

   task automatic test_align();
      // Quarter rate, markers on words 3, 7 and 11 fill the 12-word window
      apply_reset();
      set_mode(FIFO_4X);
      send_markers(4, 12);
      // Half rate, every third word never matches
      apply_reset();
      set_mode(FIFO_2X);
      send_markers(3, 99);
      // Full rate locks on the first enabled cycle
      apply_reset();
      set_mode(FIFO_1X);
      @(negedge wr_clk);
      check("wa_lock", wa_lock, 1'b0);
      @(posedge wr_clk);
      wa_en <= 1'b1;
      @(posedge wr_clk);
      wa_en <= 1'b0;
      @(negedge wr_clk);
      check("wa_lock", wa_lock, 1'b1);
   endtask

   // **************************************************
   // Main sequence and watchdog
   // **************************************************
   initial begin
      rst_req   = 1'b0;
      wr_en     = 1'b0;
      wr_data   = '0;
      rd_en     = 1'b0;
      wa_en     = 1'b0;
      fifo_mode = FIFO_1X;
      thresh    = '{empty: 4'd0, pempty: 4'd2, full: 4'd14, pfull: 4'd10};
      wait_reset_done();
      test_reset_values();
      report_test("reset values");
      test_full_rate_order();
      report_test("full rate ordering");
      test_packing(FIFO_2X, 2);
      test_packing(FIFO_4X, 4);
      report_test("rate packing");
      test_flags();
      report_test("threshold flags");
      test_align();
      report_test("word alignment");
      $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      #(RUN_CYCLES * 4 * PERIOD);
      $display("Watchdog expired before all tests completed");
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: test/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

// Clocks and synchronous resets for both FIFO domains
module tb_clkgen #(
   parameter int PERIOD     = 40,
   parameter int RD_OFFSET  = 13,   // rd_clk lags wr_clk
   parameter int RST_CYCLES = 10
) (
   input  wire  rst_req,    // Restarts the reset sequence
   output logic wr_clk,
   output logic rd_clk,
   output logic wr_rst_n,
   output logic rd_rst_n
);

   int wr_cnt = RST_CYCLES;   // Cycles of reset left
   int rd_cnt = RST_CYCLES;

   initial begin
      wr_clk = 1'b0;
      forever begin
         #(PERIOD / 2) wr_clk = ~wr_clk;
      end
   end

   initial begin
      rd_clk = 1'b0;
      #(RD_OFFSET);   // Phase offset between the domains
      forever begin
         #(PERIOD / 2) rd_clk = ~rd_clk;
      end
   end

   // Reset counters, one per domain
   always @(posedge wr_clk) begin
      if (rst_req) begin
         wr_cnt <= RST_CYCLES;
      end else if (wr_cnt != 0) begin
         wr_cnt <= wr_cnt - 1;
      end
   end

   always @(posedge rd_clk) begin
      if (rst_req) begin
         rd_cnt <= RST_CYCLES;
      end else if (rd_cnt != 0) begin
         rd_cnt <= rd_cnt - 1;
      end
   end

   assign wr_rst_n = (wr_cnt == 0);
   assign rd_rst_n = (rd_cnt == 0);

endmodule

`default_nettype wire

// File: verilog/rxdp_async_fifo.sv
`timescale 1ns/1ns
`default_nettype none

// Receive datapath FIFO of the die-to-die adapter
module rxdp_async_fifo
   import rxdp_cfg_pkg::*;
   import rxdp_fifo_pkg::*;
#(
   parameter int DWIDTH = 80,   // Word width
   parameter int AWIDTH = 4     // Entry address width
) (
   input  wire                 wr_clk,
   input  wire                 wr_rst_n,
   input  wire                 wr_en,
   input  wire [DWIDTH-1:0]    wr_data,
   input  wire                 rd_clk,
   input  wire                 rd_rst_n,
   input  wire                 rd_en,
   input  wire fifo_thresh_t   thresh,
   input  wire fifo_mode_e     fifo_mode,
   input  wire                 wa_en,
   output logic [4*DWIDTH-1:0] rd_data,
   output logic                wa_lock,
   output fifo_flags_t         wr_flags,
   output fifo_flags_t         rd_flags
);

   localparam int DEPTH = 1 << AWIDTH;

   logic                entry_we;
   logic [4*DWIDTH-1:0] entry_data;
   logic [DEPTH-1:0]    wr_ptr_oh;
   logic [DEPTH-1:0]    rd_ptr_oh;
   logic [AWIDTH-1:0]   wr_numdata;
   logic [AWIDTH-1:0]   rd_numdata;
   logic                marker;

   assign marker = wr_data[DWIDTH-2];   // Alignment marker bit

   // **************************************************
   // Write side
   // **************************************************
   rxdp_rate_packer #(.DWIDTH(DWIDTH)) packer (
      .wr_clk     (wr_clk),
      .wr_rst_n   (wr_rst_n),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .fifo_mode  (fifo_mode),
      .entry_we   (entry_we),
      .entry_data (entry_data)
   );

   rxdp_word_align word_align (
      .wr_clk    (wr_clk),
      .wr_rst_n  (wr_rst_n),
      .marker    (marker),
      .wa_en     (wa_en),
      .fifo_mode (fifo_mode),
      .wa_lock   (wa_lock)
   );

   // Pointers and storage
   rxdp_fifo_ptr #(.AWIDTH(AWIDTH)) pointers (
      .wr_clk     (wr_clk),
      .wr_rst_n   (wr_rst_n),
      .rd_clk     (rd_clk),
      .rd_rst_n   (rd_rst_n),
      .entry_we   (entry_we),
      .rd_en      (rd_en),
      .wr_ptr_oh  (wr_ptr_oh),
      .rd_ptr_oh  (rd_ptr_oh),
      .wr_numdata (wr_numdata),
      .rd_numdata (rd_numdata)
   );

   rxdp_fifo_ram #(.DWIDTH(DWIDTH), .AWIDTH(AWIDTH)) ram (
      .wr_clk     (wr_clk),
      .entry_we   (entry_we),
      .wr_ptr_oh  (wr_ptr_oh),
      .entry_data (entry_data),
      .rd_ptr_oh  (rd_ptr_oh),
      .rd_data    (rd_data)
   );

   // **************************************************
   // Flags per domain
   // **************************************************
   rxdp_fifo_flags wr_flag_gen (
      .clk     (wr_clk),
      .rst_n   (wr_rst_n),
      .numdata (wr_numdata),
      .thresh  (thresh),
      .flags   (wr_flags)
   );

   rxdp_fifo_flags rd_flag_gen (
      .clk     (rd_clk),
      .rst_n   (rd_rst_n),
      .numdata (rd_numdata),
      .thresh  (thresh),
      .flags   (rd_flags)
   );

endmodule

`default_nettype wire

// File: verilog/rxdp_fifo_flags.sv
`timescale 1ns/1ns
`default_nettype none

// Registered threshold flags for one clock domain
module rxdp_fifo_flags
   import rxdp_cfg_pkg::*;
   import rxdp_fifo_pkg::*;
(
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire [THRESH_W-1:0]  numdata,   // Fill level in this domain
   input  wire fifo_thresh_t   thresh,
   output fifo_flags_t         flags
);

   // **************************************************
   // Threshold compare, one cycle behind the level
   // **************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flags.empty  <= 1'b1;   // Empty after reset
         flags.pempty <= 1'b1;
         flags.full   <= 1'b0;
         flags.pfull  <= 1'b0;
      end else begin
         // Lower bounds
         flags.empty  <= (numdata <= thresh.empty);
         flags.pempty <= (numdata <= thresh.pempty);
         // Upper bounds
         flags.full   <= (numdata >= thresh.full);
         flags.pfull  <= (numdata >= thresh.pfull);
      end
   end

endmodule

`default_nettype wire

// File: verilog/rxdp_fifo_ram.sv
`timescale 1ns/1ns
`default_nettype none

// Dual-clock entry storage, one-hot addressed on both ports
module rxdp_fifo_ram #(
   parameter int DWIDTH = 80,
   parameter int AWIDTH = 4
) (
   input  wire                     wr_clk,
   input  wire                     entry_we,
   input  wire [(1<<AWIDTH)-1:0]   wr_ptr_oh,
   input  wire [4*DWIDTH-1:0]      entry_data,
   input  wire [(1<<AWIDTH)-1:0]   rd_ptr_oh,
   output logic [4*DWIDTH-1:0]     rd_data       // Show-ahead output
);

   localparam int DEPTH = 1 << AWIDTH;

   logic [4*DWIDTH-1:0] mem [DEPTH];   // Four lanes per entry

   // **************************************************
   // Write port
   // **************************************************
   always_ff @(posedge wr_clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (entry_we && wr_ptr_oh[i]) begin
            mem[i] <= entry_data;
         end
      end
   end

   // OR-tree read through the one-hot pointer
   always_comb begin
      rd_data = '0;
      for (int i = 0; i < DEPTH; i++) begin
         if (rd_ptr_oh[i]) begin
            rd_data = rd_data | mem[i];
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/rxdp_rate_packer.sv
`timescale 1ns/1ns
`default_nettype none

// Gathers one, two or four words into one four-lane entry
module rxdp_rate_packer
   import rxdp_cfg_pkg::*;
#(
   parameter int DWIDTH = 80
) (
   input  wire                  wr_clk,
   input  wire                  wr_rst_n,
   input  wire                  wr_en,        // One strobe per word
   input  wire     [DWIDTH-1:0] wr_data,
   input  wire fifo_mode_e      fifo_mode,
   output logic                 entry_we,     // Entry complete this cycle
   output logic [4*DWIDTH-1:0]  entry_data
);

   fifo_mode_e        mode_q;     // Mode of the previous cycle
   logic [1:0]        lane_cnt;
   logic [1:0]        cur_cnt;    // Lane of the current word
   logic              mode_chg;
   logic              last_lane;
   logic [DWIDTH-1:0] lane0_q;    // Earlier words of the group
   logic [DWIDTH-1:0] lane1_q;
   logic [DWIDTH-1:0] lane2_q;

   assign mode_chg = (fifo_mode != mode_q);
   assign cur_cnt  = mode_chg ? 2'd0 : lane_cnt;   // Restart on mode change

   always_comb begin
      case (fifo_mode)
         FIFO_2X: last_lane = cur_cnt[0];
         FIFO_4X: last_lane = (cur_cnt == 2'd3);
         default: last_lane = 1'b1;   // Full rate and register mode
      endcase
   end

   assign entry_we = wr_en & last_lane;

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         mode_q   <= FIFO_1X;
         lane_cnt <= 2'd0;
      end else begin
         mode_q   <= fifo_mode;
         lane_cnt <= cur_cnt;
         if (wr_en) begin
            lane_cnt <= last_lane ? 2'd0 : cur_cnt + 2'd1;
         end
      end
   end

   // Hold words until the group is complete
   always_ff @(posedge wr_clk) begin
      if (wr_en && !last_lane) begin
         case (cur_cnt)
            2'd0:    lane0_q <= wr_data;
            2'd1:    lane1_q <= wr_data;
            default: lane2_q <= wr_data;
         endcase
      end
   end

   // Current word fills the last lane and the earliest word sits in lane 0
   always_comb begin
      case (fifo_mode)
         FIFO_2X: entry_data = {{(2*DWIDTH){1'b0}}, wr_data, lane0_q};
         FIFO_4X: entry_data = {wr_data, lane2_q, lane1_q, lane0_q};
         default: entry_data = {{(3*DWIDTH){1'b0}}, wr_data};
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/rxdp_fifo_ptr.sv
`timescale 1ns/1ns
`default_nettype none

// Write and read pointers with gray-code crossing in both directions
module rxdp_fifo_ptr #(
   parameter int AWIDTH = 4
) (
   input  wire                     wr_clk,
   input  wire                     wr_rst_n,
   input  wire                     rd_clk,
   input  wire                     rd_rst_n,
   input  wire                     entry_we,     // Entry write strobe
   input  wire                     rd_en,        // Entry read strobe
   output logic [(1<<AWIDTH)-1:0]  wr_ptr_oh,
   output logic [(1<<AWIDTH)-1:0]  rd_ptr_oh,
   output logic [AWIDTH-1:0]       wr_numdata,   // Fill level seen on wr_clk
   output logic [AWIDTH-1:0]       rd_numdata    // Fill level seen on rd_clk
);

   localparam int DEPTH = 1 << AWIDTH;

   logic [AWIDTH-1:0] wr_bin;
   logic [AWIDTH-1:0] wr_bin_nxt;
   logic [AWIDTH-1:0] wr_gray;      // Registered, safe to cross
   logic [AWIDTH-1:0] rd_bin;
   logic [AWIDTH-1:0] rd_bin_nxt;
   logic [AWIDTH-1:0] rd_gray;
   logic [AWIDTH-1:0] wr_gray_m;    // rd_clk synchronizer stages
   logic [AWIDTH-1:0] wr_gray_s;
   logic [AWIDTH-1:0] rd_gray_m;    // wr_clk synchronizer stages
   logic [AWIDTH-1:0] rd_gray_s;

   function automatic logic [AWIDTH-1:0] bin2gray(input logic [AWIDTH-1:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [AWIDTH-1:0] gray2bin(input logic [AWIDTH-1:0] g);
      logic [AWIDTH-1:0] b;
      b[AWIDTH-1] = g[AWIDTH-1];
      for (int i = AWIDTH - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];   // Running XOR from the top
      end
      return b;
   endfunction

   assign wr_bin_nxt = wr_bin + 1'b1;
   assign rd_bin_nxt = rd_bin + 1'b1;

   // **************************************************
   // Write clock domain
   // **************************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_bin    <= '0;
         wr_gray   <= '0;
         wr_ptr_oh <= {{(DEPTH-1){1'b0}}, 1'b1};
         rd_gray_m <= '0;
         rd_gray_s <= '0;
      end else begin
         rd_gray_m <= rd_gray;     // Two-flop sync of read pointer
         rd_gray_s <= rd_gray_m;
         if (entry_we) begin
            wr_bin    <= wr_bin_nxt;
            wr_gray   <= bin2gray(wr_bin_nxt);
            wr_ptr_oh <= {wr_ptr_oh[DEPTH-2:0], wr_ptr_oh[DEPTH-1]};   // Rotate
         end
      end
   end

   assign wr_numdata = wr_bin - gray2bin(rd_gray_s);   // Wraps modulo DEPTH

   // **************************************************
   // Read clock domain
   // **************************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_bin    <= '0;
         rd_gray   <= '0;
         rd_ptr_oh <= {{(DEPTH-1){1'b0}}, 1'b1};
         wr_gray_m <= '0;
         wr_gray_s <= '0;
      end else begin
         wr_gray_m <= wr_gray;   // Two-flop sync of write pointer
         wr_gray_s <= wr_gray_m;
         if (rd_en) begin
            rd_bin    <= rd_bin_nxt;
            rd_gray   <= bin2gray(rd_bin_nxt);
            rd_ptr_oh <= {rd_ptr_oh[DEPTH-2:0], rd_ptr_oh[DEPTH-1]};
         end
      end
   end

   assign rd_numdata = gray2bin(wr_gray_s) - rd_bin;

   // One-hot rings stay single-bit and track the binary counters
   a_wr_oh: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      $onehot(wr_ptr_oh) && wr_ptr_oh[wr_bin]);
   a_rd_oh: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      $onehot(rd_ptr_oh) && rd_ptr_oh[rd_bin]);

endmodule

`default_nettype wire

// File: verilog/rxdp_word_align.sv
`timescale 1ns/1ns
`default_nettype none

// Marker hunt and sticky lock on the write clock
module rxdp_word_align
   import rxdp_cfg_pkg::*;
   import rxdp_fifo_pkg::*;
(
   input  wire             wr_clk,
   input  wire             wr_rst_n,
   input  wire             marker,      // Marker bit of the incoming word
   input  wire             wa_en,       // Alignment enable
   input  wire fifo_mode_e fifo_mode,
   output logic            wa_lock
);

   wa_state_e   state;
   logic [11:0] wm_history;   // Newest marker in bit 0
   logic        pattern_hit;

   // Pattern that matches the rate mode
   always_comb begin
      case (fifo_mode)
         FIFO_4X: pattern_hit = (wm_history == 12'h111);      // One in every fourth word
         FIFO_2X: pattern_hit = (wm_history[5:0] == 6'h15);   // One in every second word
         default: pattern_hit = 1'b1;                         // Full rate locks at once
      endcase
   end

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         state      <= WA_HUNT;
         wm_history <= '0;
      end else if (wa_en) begin
         wm_history <= {wm_history[10:0], marker};   // Shift only while enabled
         case (state)
            WA_HUNT: begin
               if (pattern_hit) begin
                  state <= WA_LOCKED;
               end
            end
            default: state <= WA_LOCKED;   // Never leaves lock
         endcase
      end
   end

   assign wa_lock = (state == WA_LOCKED);

endmodule

`default_nettype wire

// File: verilog/rxdp_fifo_pkg.sv
`default_nettype none

// Status types of the receive datapath FIFO
package rxdp_fifo_pkg;

   // **************************************************
   // Per-domain level flags
   // **************************************************
   typedef struct packed {
      logic empty;    // Fill level at or below empty threshold
      logic pempty;   // Partially empty
      logic full;     // Fill level at or above full threshold
      logic pfull;    // Partially full
   } fifo_flags_t;

   // Word alignment states
   typedef enum logic {
      WA_HUNT   = 1'b0,   // Searching for marker pattern
      WA_LOCKED = 1'b1    // Sticky until reset
   } wa_state_e;

endpackage

`default_nettype wire

// File: verilog/rxdp_cfg_pkg.sv
`default_nettype none

// Configuration types for the receive datapath FIFO
package rxdp_cfg_pkg;

   // Threshold field width, equal to the default AWIDTH
   // AWIDTH must stay at 4 for as long as fifo_thresh_t is used
   localparam int THRESH_W = 4;

   // **************************************************
   // Rate mode
   // **************************************************
   typedef enum logic [1:0] {
      FIFO_1X = 2'b00,   // Full rate
      FIFO_2X = 2'b01,   // Half rate with two words per entry
      FIFO_4X = 2'b10,   // Quarter rate with four words per entry
      REG_MOD = 2'b11    // Register mode, handled as full rate
   } fifo_mode_e;

   // Programmable thresholds, 16 bits in all
   typedef struct packed {
      logic [THRESH_W-1:0] empty;    // Empty at or below
      logic [THRESH_W-1:0] pempty;   // Partially empty at or below
      logic [THRESH_W-1:0] full;     // Full at or above
      logic [THRESH_W-1:0] pfull;    // Partially full at or above
   } fifo_thresh_t;

endpackage

`default_nettype wire
